//--- miner_cfg.svh
`ifndef MINER_CFG_SVH
`define MINER_CFG_SVH

// search stages in the chain
`define MINER_NUM_CORES 4

`define MINER_BROADCAST_CNT 16 // cycles per block
`define MINER_ROUND_CNT 4      // hash rounds = core latency

// h0, h1, h2 and the target
`define MINER_HDR_WORDS 4

`endif

//--- minerPkg.sv
`include "miner_cfg.svh"

package minerPkg;

	typedef logic [31:0] word_t; // header or hash word
	typedef logic [31:0] nonce_t;

	typedef logic [`MINER_NUM_CORES-1:0] hitVec_t; // one bit per core

	// broadcast cycle count
	typedef logic [$clog2(`MINER_BROADCAST_CNT + 1)-1:0] base_t;

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		BROADCAST
	} blkState_e;

	typedef enum logic [1:0] {
		WAIT,
		SEARCH,
		DONE
	} decState_e;

	localparam word_t MIX_CONST = 32'h9E3779B9; // added once per round

endpackage

//--- blockStorage.sv
`timescale 1ns/100ps
`include "miner_cfg.svh"

module blockStorage (
	input  logic            clk,
	input  logic            arstN_i,
	input  minerPkg::word_t blkWord_i,
	input  logic            blkWordValid_i,
	output logic            bcValid_o,
	output logic            bcNewBlock_o,
	output minerPkg::base_t bcBase_o,
	output minerPkg::word_t bcHdr0_o,
	output minerPkg::word_t bcHdr1_o,
	output minerPkg::word_t bcHdr2_o,
	output minerPkg::word_t bcTarget_o
);

	localparam int WCNT_W = $clog2(`MINER_HDR_WORDS);

	minerPkg::blkState_e state;
	logic [WCNT_W-1:0] wordCnt;
	minerPkg::word_t hdrQ [`MINER_HDR_WORDS-1]; // data words while loading
	logic wordTake;
	logic lastWord;

	assign wordTake = blkWordValid_i && (state != minerPkg::BROADCAST); // ignored while broadcasting
	assign lastWord = wordTake && (wordCnt == WCNT_W'(`MINER_HDR_WORDS - 1));

	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i) begin
			state <= minerPkg::IDLE;
			wordCnt <= '0;
			bcBase_o <= '0;
		end else begin
			case (state)
				minerPkg::IDLE: if (wordTake) begin
					wordCnt <= wordCnt + 1'b1;
					state <= minerPkg::LOAD;
				end
				minerPkg::LOAD: if (lastWord) begin
					wordCnt <= '0;
					state <= minerPkg::BROADCAST;
				end else if (wordTake) begin
					wordCnt <= wordCnt + 1'b1;
				end
				minerPkg::BROADCAST: if (bcBase_o == minerPkg::base_t'(`MINER_BROADCAST_CNT - 1)) begin
					bcBase_o <= '0;
					state <= minerPkg::IDLE;
				end else begin
					bcBase_o <= bcBase_o + 1'b1;
				end
				default: state <= minerPkg::IDLE;
			endcase
		end
	end

	// outputs only change on the target strobe, so they hold while the chain drains
	always_ff @(posedge clk) begin
		if (lastWord) begin
			bcHdr0_o <= hdrQ[0];
			bcHdr1_o <= hdrQ[1];
			bcHdr2_o <= hdrQ[2];
			bcTarget_o <= blkWord_i;
		end else if (wordTake) begin
			hdrQ[wordCnt] <= blkWord_i;
		end
	end

	assign bcValid_o = (state == minerPkg::BROADCAST);
	assign bcNewBlock_o = bcValid_o && (bcBase_o == '0); // first broadcast cycle

endmodule

//--- hashCore.sv
`timescale 1ns/100ps
`include "miner_cfg.svh"

module hashCore (
	input  logic             clk,
	input  logic             arstN_i,
	input  minerPkg::nonce_t nonce_i,
	input  minerPkg::word_t  hdr0_i,
	input  minerPkg::word_t  hdr1_i,
	input  minerPkg::word_t  hdr2_i,
	input  minerPkg::word_t  target_i,
	input  logic             valid_i,
	output logic             hit_o
);

	localparam int RND = `MINER_ROUND_CNT;

	minerPkg::word_t stQ [RND]; // one register per round
	logic [RND-1:0] vldQ;
	minerPkg::word_t hdr [3];

	function automatic minerPkg::word_t mixRound(input minerPkg::word_t s,
	                                             input minerPkg::word_t h);
		minerPkg::word_t x;
		x = s ^ h;
		return {x[24:0], x[31:25]} + minerPkg::MIX_CONST; // rotl 7, then add
	endfunction

	assign hdr[0] = hdr0_i;
	assign hdr[1] = hdr1_i;
	assign hdr[2] = hdr2_i;

	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i)
			vldQ <= '0;
		else
			vldQ <= (vldQ << 1) | RND'(valid_i);
	end

	always_ff @(posedge clk) begin
		stQ[0] <= mixRound(nonce_i, hdr[0]); // state starts as the nonce
		for (int r = 1; r < RND; r++)
			stQ[r] <= mixRound(stQ[r-1], hdr[r % 3]);
	end

	assign hit_o = vldQ[RND-1] && (stQ[RND-1] < target_i); // unsigned compare

endmodule

//--- latticeBlock.sv
`timescale 1ns/100ps
`include "miner_cfg.svh"

module latticeBlock #(
	parameter int INDEX = 0
) (
	input  logic              clk,
	input  logic              arstN_i,
	input  logic              bcValid_i,
	input  logic              bcNewBlock_i,
	input  minerPkg::base_t   bcBase_i,
	input  minerPkg::word_t   bcHdr0_i,
	input  minerPkg::word_t   bcHdr1_i,
	input  minerPkg::word_t   bcHdr2_i,
	input  minerPkg::word_t   bcTarget_i,
	output logic              bcValid_o,
	output logic              bcNewBlock_o,
	output minerPkg::base_t   bcBase_o,
	output minerPkg::word_t   bcHdr0_o,
	output minerPkg::word_t   bcHdr1_o,
	output minerPkg::word_t   bcHdr2_o,
	output minerPkg::word_t   bcTarget_o,
	input  minerPkg::hitVec_t hits_i,
	input  logic              hitsValid_i,
	input  logic              hitsNewBlock_i,
	output minerPkg::hitVec_t hits_o,
	output logic              hitsValid_o,
	output logic              hitsNewBlock_o
);

	localparam int RND = `MINER_ROUND_CNT;

	minerPkg::nonce_t nonce;
	logic coreHit;
	logic [RND-1:0] vldDly; // matches the core latency
	logic [RND-1:0] nbDly;

	assign nonce = minerPkg::nonce_t'(bcBase_i) * minerPkg::nonce_t'(`MINER_NUM_CORES)
		+ minerPkg::nonce_t'(INDEX);

	hashCore core_i (
		.clk,
		.arstN_i,
		.nonce_i(nonce),
		.hdr0_i(bcHdr0_i),
		.hdr1_i(bcHdr1_i),
		.hdr2_i(bcHdr2_i),
		.target_i(bcTarget_i),
		.valid_i(bcValid_i),
		.hit_o(coreHit)
	);

	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i) begin
			bcValid_o <= 1'b0;
			bcNewBlock_o <= 1'b0;
			vldDly <= '0;
			nbDly <= '0;
			hitsValid_o <= 1'b0;
			hitsNewBlock_o <= 1'b0;
		end else begin
			bcValid_o <= bcValid_i;
			bcNewBlock_o <= bcNewBlock_i;
			vldDly <= (vldDly << 1) | RND'(bcValid_i);
			nbDly <= (nbDly << 1) | RND'(bcNewBlock_i);
			// the first stage has no upstream qualifiers
			hitsValid_o <= (INDEX == 0) ? vldDly[RND-1] : hitsValid_i;
			hitsNewBlock_o <= (INDEX == 0) ? nbDly[RND-1] : hitsNewBlock_i;
		end
	end

	always_ff @(posedge clk) begin
		bcBase_o <= bcBase_i;
		bcHdr0_o <= bcHdr0_i;
		bcHdr1_o <= bcHdr1_i;
		bcHdr2_o <= bcHdr2_i;
		bcTarget_o <= bcTarget_i;
		hits_o <= hits_i | (minerPkg::hitVec_t'(coreHit) << INDEX); // own bit joins the vector
	end

endmodule

//--- nonceDecoder.sv
`timescale 1ns/100ps
`include "miner_cfg.svh"

module nonceDecoder (
	input  logic              clk,
	input  logic              arstN_i,
	input  logic              valid_i,
	input  logic              newBlock_i,
	input  minerPkg::hitVec_t hits_i,
	output logic              valid_o,
	output logic              success_o,
	output minerPkg::nonce_t  nonce_o
);

	localparam int NC = `MINER_NUM_CORES;
	localparam int K_W = (NC > 1) ? $clog2(NC) : 1;

	minerPkg::decState_e state;
	minerPkg::base_t cnt;
	minerPkg::base_t curCnt;
	logic [K_W-1:0] firstHit;
	logic anyHit;
	logic active;
	logic lastCycle;

	// lowest core index wins
	always_comb begin
		firstHit = '0;
		for (int k = NC - 1; k >= 0; k--)
			if (hits_i[k])
				firstHit = K_W'(k);
	end

	assign anyHit = |hits_i;
	assign curCnt = newBlock_i ? '0 : cnt; // new block restarts the count
	assign active = valid_i && (newBlock_i || (state == minerPkg::SEARCH));
	assign lastCycle = (curCnt == minerPkg::base_t'(`MINER_BROADCAST_CNT - 1));

	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i) begin
			state <= minerPkg::WAIT;
			cnt <= '0;
			valid_o <= 1'b0;
		end else begin
			valid_o <= 1'b0;
			if (active) begin
				if (anyHit || lastCycle) begin
					valid_o <= 1'b1; // one result per block
					state <= minerPkg::DONE;
				end else begin
					cnt <= curCnt + 1'b1;
					state <= minerPkg::SEARCH;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (active) begin
			success_o <= anyHit;
			nonce_o <= anyHit ? minerPkg::nonce_t'(curCnt) * minerPkg::nonce_t'(NC)
				+ minerPkg::nonce_t'(firstHit) : '0;
		end
	end

endmodule

//--- nonceBuffer.sv
`timescale 1ns/100ps

module nonceBuffer (
	input  logic             clk,
	input  logic             arstN_i,
	input  logic             valid_i,
	input  logic             success_i,
	input  minerPkg::nonce_t nonce_i,
	input  logic             readReady_i,
	output logic             resultValid_o,
	output logic             success_o,
	output minerPkg::nonce_t nonce_o,
	output logic             error_o
);

	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i) begin
			resultValid_o <= 1'b0;
			error_o <= 1'b0;
		end else begin
			if (valid_i)
				resultValid_o <= 1'b1;
			else if (readReady_i)
				resultValid_o <= 1'b0;

			if (valid_i && resultValid_o && !readReady_i)
				error_o <= 1'b1; // unread result was overwritten
			else if (readReady_i)
				error_o <= 1'b0;
		end
	end

	// newest result always wins
	always_ff @(posedge clk) begin
		if (valid_i) begin
			success_o <= success_i;
			nonce_o <= nonce_i;
		end
	end

endmodule

//--- bcMiner.sv
`timescale 1ns/100ps
`include "miner_cfg.svh"

module bcMiner (
	input  logic             clk,
	input  logic             arstN_i,
	input  minerPkg::word_t  blkWord_i,
	input  logic             blkWordValid_i,
	input  logic             readReady_i,
	output logic             resultValid_o,
	output logic             success_o,
	output minerPkg::nonce_t nonce_o,
	output logic             error_o
);

	localparam int NC = `MINER_NUM_CORES;

	// entry i feeds stage i, entry NC leaves the last stage
	logic bcValid [NC+1];
	logic bcNewBlock [NC+1];
	minerPkg::base_t bcBase [NC+1];
	minerPkg::word_t bcHdr0 [NC+1];
	minerPkg::word_t bcHdr1 [NC+1];
	minerPkg::word_t bcHdr2 [NC+1];
	minerPkg::word_t bcTarget [NC+1];
	minerPkg::hitVec_t hits [NC+1];
	logic hitsValid [NC+1];
	logic hitsNewBlock [NC+1];

	logic decValid;
	logic decSuccess;
	minerPkg::nonce_t decNonce;

	blockStorage bs_i (
		.clk,
		.arstN_i,
		.blkWord_i,
		.blkWordValid_i,
		.bcValid_o(bcValid[0]),
		.bcNewBlock_o(bcNewBlock[0]),
		.bcBase_o(bcBase[0]),
		.bcHdr0_o(bcHdr0[0]),
		.bcHdr1_o(bcHdr1[0]),
		.bcHdr2_o(bcHdr2[0]),
		.bcTarget_o(bcTarget[0])
	);

	assign hits[0] = '0; // empty vector into the chain
	assign hitsValid[0] = 1'b0;
	assign hitsNewBlock[0] = 1'b0;

	for (genvar i = 0; i < NC; i++) begin : genChain
		latticeBlock #(.INDEX(i)) lblock_i (
			.clk,
			.arstN_i,
			.bcValid_i(bcValid[i]),
			.bcNewBlock_i(bcNewBlock[i]),
			.bcBase_i(bcBase[i]),
			.bcHdr0_i(bcHdr0[i]),
			.bcHdr1_i(bcHdr1[i]),
			.bcHdr2_i(bcHdr2[i]),
			.bcTarget_i(bcTarget[i]),
			.bcValid_o(bcValid[i+1]),
			.bcNewBlock_o(bcNewBlock[i+1]),
			.bcBase_o(bcBase[i+1]),
			.bcHdr0_o(bcHdr0[i+1]),
			.bcHdr1_o(bcHdr1[i+1]),
			.bcHdr2_o(bcHdr2[i+1]),
			.bcTarget_o(bcTarget[i+1]),
			.hits_i(hits[i]),
			.hitsValid_i(hitsValid[i]),
			.hitsNewBlock_i(hitsNewBlock[i]),
			.hits_o(hits[i+1]),
			.hitsValid_o(hitsValid[i+1]),
			.hitsNewBlock_o(hitsNewBlock[i+1])
		);
	end

	nonceDecoder ndecode_i (
		.clk,
		.arstN_i,
		.valid_i(hitsValid[NC]),
		.newBlock_i(hitsNewBlock[NC]),
		.hits_i(hits[NC]),
		.valid_o(decValid),
		.success_o(decSuccess),
		.nonce_o(decNonce)
	);

	nonceBuffer nbuffer_i (
		.clk,
		.arstN_i,
		.valid_i(decValid),
		.success_i(decSuccess),
		.nonce_i(decNonce),
		.readReady_i,
		.resultValid_o,
		.success_o,
		.nonce_o,
		.error_o
	);

endmodule

//--- bcMiner_props.sv
`timescale 1ns/100ps
`include "miner_cfg.svh"

module bcMinerProps (
	input logic             clk,
	input logic             arstN_i,
	input logic             readReady_i,
	input logic             resultValid_o,
	input logic             success_o,
	input minerPkg::nonce_t nonce_o,
	input logic             error_o
);

	localparam int NONCE_CNT = `MINER_NUM_CORES * `MINER_BROADCAST_CNT;

	int failCount = 0;

	resetQuiet: assert property (@(posedge clk) !arstN_i |-> !resultValid_o && !error_o)
		else begin
			failCount++;
			$error("result or error flag high during reset");
		end

	// a held nonce may only change together with the overflow flag
	nonceHeld: assert property (@(posedge clk) disable iff (!arstN_i)
		resultValid_o && !readReady_i |=> $stable(nonce_o) || error_o)
		else begin
			failCount++;
			$error("nonce_o changed while the result was held");
		end

	nonceRange: assert property (@(posedge clk) disable iff (!arstN_i)
		resultValid_o && success_o |-> nonce_o < NONCE_CNT)
		else begin
			failCount++;
			$error("successful nonce outside the search range");
		end

endmodule

bind bcMiner bcMinerProps props_i (.*);

//--- tb_bcMiner.sv
`timescale 1ns/100ps
`include "miner_cfg.svh"

module tb_bcMiner;

	localparam int NC = `MINER_NUM_CORES;
	localparam int BC = `MINER_BROADCAST_CNT;
	localparam int RC = `MINER_ROUND_CNT;
	localparam int FIXED_ROWS = 7;
	localparam int ROWS = FIXED_ROWS + 3; // three rows with random headers
	localparam int LIMIT = ROWS * (BC + NC + RC + 20);

	typedef struct {
		minerPkg::word_t h0;
		minerPkg::word_t h1;
		minerPkg::word_t h2;
		minerPkg::word_t target;
		logic readAfter;
	} row_t;

	logic clk;
	logic arstN_i;
	minerPkg::word_t blkWord_i;
	logic blkWordValid_i;
	logic readReady_i;
	logic resultValid_o;
	logic success_o;
	minerPkg::nonce_t nonce_o;
	logic error_o;

	row_t rows [ROWS];
	integer seed;
	int cycles = 0;
	int flagErrors = 0;
	int nonceErrors = 0;
	int latencyErrors = 0;

	bcMiner dut_i (.*);

	always #10 clk = ~clk;

	task automatic printCounts();
		$display("flag errors: %0d, nonce errors: %0d, latency errors: %0d, assertion failures: %0d",
			flagErrors, nonceErrors, latencyErrors, dut_i.props_i.failCount);
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("DUT never produced a result within %0d cycles", LIMIT);
			printCounts();
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic minerPkg::word_t refHash(input minerPkg::nonce_t n, input row_t r);
		minerPkg::word_t s;
		minerPkg::word_t h;
		s = n;
		for (int k = 0; k < RC; k++) begin
			case (k % 3)
				0: h = r.h0;
				1: h = r.h1;
				default: h = r.h2;
			endcase
			s = s ^ h;
			s = (s << 7) | (s >> 25);
			s = s + 32'h9E37_79B9;
		end
		return s;
	endfunction

	// first nonce in search order whose hash is below the target
	function automatic logic refSearch(input row_t r, output minerPkg::nonce_t n);
		n = '0;
		for (int k = 0; k < NC * BC; k++) begin
			if (refHash(k, r) < r.target) begin
				n = k;
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	task automatic checkFlag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			flagErrors++;
		end
	endtask

	task automatic checkNonce(input string what, input minerPkg::nonce_t got,
	                          input minerPkg::nonce_t exp);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			nonceErrors++;
		end
	endtask

	task automatic checkLatency(input string what, input int got, input int exp);
		if (got != exp) begin
			$display("ERROR at %0t ns: %s is %0d cycles, expected %0d", $time, what, got, exp);
			latencyErrors++;
		end
	endtask

	task automatic strobeWord(input minerPkg::word_t w);
		@(negedge clk);
		blkWord_i = w;
		blkWordValid_i = 1'b1;
	endtask

	initial begin
		row_t r;
		minerPkg::nonce_t expNonce;
		logic expOk;
		logic prevUnread;
		int startCycle;
		int expLat;
		clk = 1'b0;
		arstN_i = 1'b0;
		blkWord_i = '0;
		blkWordValid_i = 1'b0;
		readReady_i = 1'b0;
		seed = 41642;
		prevUnread = 1'b0;
		rows[0] = '{32'h1111_1111, 32'h2222_2222, 32'h3333_3333, 32'hFFFF_FFFF, 1'b1}; // easy
		rows[1] = '{32'h1111_1111, 32'h2222_2222, 32'h3333_3333, 32'h0000_0000, 1'b1}; // no hit
		rows[2] = '{32'hDEAD_BEEF, 32'h0123_4567, 32'h89AB_CDEF, 32'h0800_0000, 1'b1};
		rows[3] = '{32'hCAFE_F00D, 32'h0BAD_C0DE, 32'h1357_9BDF, 32'h0400_0000, 1'b1};
		rows[4] = '{32'hA5A5_A5A5, 32'h5A5A_5A5A, 32'h0F0F_0F0F, 32'h1000_0000, 1'b0}; // left unread
		rows[5] = '{32'h7654_3210, 32'hFEDC_BA98, 32'h0000_0000, 32'h0800_0000, 1'b1};
		rows[6] = '{32'h0000_0001, 32'h0000_0002, 32'h0000_0003, 32'h0200_0000, 1'b1};
		for (int i = FIXED_ROWS; i < ROWS; i++) begin
			rows[i].h0 = $random(seed);
			rows[i].h1 = $random(seed);
			rows[i].h2 = $random(seed);
			rows[i].target = 32'h0C00_0000;
			rows[i].readAfter = 1'b1;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		arstN_i = 1'b1;
		checkFlag("resultValid_o after reset", resultValid_o, 1'b0);
		checkFlag("error_o after reset", error_o, 1'b0);
		foreach (rows[i]) begin
			r = rows[i];
			expOk = refSearch(r, expNonce);
			// strobe to broadcast, chain, decoder and buffer, plus the broadcast cycle of the hit
			expLat = 3 + NC + RC + (expOk ? int'(expNonce) / NC : BC - 1);
			strobeWord(r.h0);
			strobeWord(r.h1);
			strobeWord(r.h2);
			strobeWord(r.target);
			startCycle = cycles;
			repeat (4) strobeWord($random(seed)); // junk while the block is broadcast
			@(negedge clk);
			blkWordValid_i = 1'b0;
			// an unread entry stays valid, so the overflow flag marks the new result
			while (!(prevUnread ? error_o : resultValid_o))
				@(negedge clk);
			checkLatency("result latency", cycles - startCycle, expLat);
			checkFlag("success_o", success_o, expOk);
			checkNonce("nonce_o", nonce_o, expNonce);
			checkFlag("error_o", error_o, prevUnread);
			if (r.readAfter) begin
				readReady_i = 1'b1;
				@(negedge clk);
				readReady_i = 1'b0;
				checkFlag("resultValid_o after read", resultValid_o, 1'b0);
				checkFlag("error_o after read", error_o, 1'b0);
			end
			prevUnread = !r.readAfter;
			while (cycles - startCycle < BC + 2) // broadcast must be over
				@(negedge clk);
		end
		printCounts();
		if (flagErrors + nonceErrors + latencyErrors + dut_i.props_i.failCount == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- list.f
+incdir+.
minerPkg.sv
blockStorage.sv
hashCore.sv
latticeBlock.sv
nonceDecoder.sv
nonceBuffer.sv
bcMiner.sv
bcMiner_props.sv
tb_bcMiner.sv

//--- Bender.yml
package:
  name: bc_miner

export_include_dirs:
  - .

sources:
  - minerPkg.sv
  - blockStorage.sv
  - hashCore.sv
  - latticeBlock.sv
  - nonceDecoder.sv
  - nonceBuffer.sv
  - bcMiner.sv
  - target: test
    files:
      - bcMiner_props.sv
      - tb_bcMiner.sv
